// ==== src.f ====
rtl/pma_pkg.sv
rtl/pma_region_table.sv
rtl/pma_access_check.sv
rtl/pma_unit.sv
tb/pma_unit_properties.sv
tb/pma_unit_tb.sv

// ==== tb/pma_unit_tb.sv ====
// testbench for the pma unit
// random cfg and check traffic, compared with a descriptor model
// inputs change on the falling edge, responses are checked one cycle later

module pma_unit_tb;

	import pma_pkg::*;

	localparam int IDLE_TIMEOUT = 20;	// cycles allowed to settle after reset

	logic      clk = 1'b0;
	logic      reset;
	logic      cs_rgn;
	cfg_req_t  cfg_req;
	logic [31:0] cfg_dato;
	chk_req_t  chk_req;
	chk_resp_t chk_resp;

	integer seed = 71;

	// ====================
	// model state
	logic [31:0] m_pmt [0:7];
	logic [31:0] m_cta [0:7];
	logic [31:0] m_at [0:7];	// byte per privilege level, rwx high nibble
	logic [31:0] m_lock [0:7];
	logic        exp_fault;	// held like the dut between checks
	logic        exp_cache;
	logic [31:0] exp_pmt;

	always #10 clk = ~clk;

	pma_unit pma_unit_inst (
		.clk      (clk),
		.reset    (reset),
		.cs_rgn   (cs_rgn),
		.cfg_req  (cfg_req),
		.cfg_dato (cfg_dato),
		.chk_req  (chk_req),
		.chk_resp (chk_resp)
	);

	always @(pma_unit_inst.properties_inst.fail_count) begin
		if (pma_unit_inst.properties_inst.fail_count != 0) begin
			$display("RESULT: FAIL");
			$fatal(1, "bound assertion failed");
		end
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic rand_bit();
		logic [31:0] w;
		w = $random(seed);
		return w[0];
	endfunction

	task automatic load_model_defaults();
		for (int r = 0; r < 8; r++) begin
			m_pmt[r] = 32'h0;
			m_cta[r] = 32'h0;
			m_at[r] = 32'h0F0F_0F0F;	// vacant, no device
			m_lock[r] = "LOCK";
		end
		m_at[7] = 32'hD0D0_D0D0;	// rom
		m_at[6] = 32'h6060_6060;	// io
		m_pmt[6] = 32'h300;
		m_at[5] = 32'h6060_6060;	// config space
		m_at[4] = 32'hF0F0_F0F0;	// scratchpad
		m_pmt[4] = 32'h2300;
		m_at[1] = 32'hF1F1_F1F1;	// dram, dev_type 1
		m_pmt[1] = 32'h2400;
	endtask

	function automatic logic [31:0] model_field(input logic [2:0] rgn, input logic [1:0] fld);
		case (fld)
			FLD_PMT: return m_pmt[rgn];
			FLD_CTA: return m_cta[rgn];
			FLD_AT: return m_at[rgn];
			default: return m_lock[rgn];
		endcase
	endfunction

	task automatic model_write(input logic [2:0] rgn, input logic [1:0] fld,
		input logic [31:0] dat);
		case (fld)
			FLD_PMT: m_pmt[rgn] = dat;
			FLD_CTA: m_cta[rgn] = dat;
			FLD_AT: m_at[rgn] = dat;
			default: m_lock[rgn] = dat;
		endcase
	endtask

	function automatic cfg_req_t cfg_op(input logic we, input int rgn, input int fld,
		input logic [31:0] dat);
		cfg_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = {rgn[2:0], fld[1:0], 4'h0};
		req.dat = dat;
		return req;
	endfunction

	function automatic chk_req_t rand_chk();
		chk_req_t    chk;
		logic [31:0] w;
		chk.valid = 1'b1;
		w = rand_word();
		chk.rgn = w[2:0];
		w = rand_word();
		chk.priv = w[1:0];
		chk.kind = access_kind_e'($unsigned($random(seed)) % 3);
		return chk;
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %s expected %h got %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ====================
	// one clock of traffic
	task automatic apply_cycle(input logic cs, input cfg_req_t req, input chk_req_t chk);
		logic [2:0]  rgn;
		logic [1:0]  fld;
		logic        sel;
		logic [31:0] exp_dato;
		logic [7:0]  ent;
		logic        need;
		cs_rgn = cs;
		cfg_req = req;
		chk_req = chk;
		rgn = req.adr[8:6];
		fld = req.adr[5:4];
		sel = cs && req.cyc && req.stb;
		exp_dato = sel ? model_field(rgn, fld) : 32'h0;
		if (chk.valid) begin
			ent = m_at[chk.rgn][chk.priv*8 +: 8];
			case (chk.kind)
				ACC_READ: need = ent[6];
				ACC_WRITE: need = ent[5];
				default: need = ent[4];	// exec
			endcase
			exp_fault = (ent[3:0] == 4'hF) || !need;
			exp_cache = ent[7] && !exp_fault;
			exp_pmt = m_pmt[chk.rgn];
		end
		// write lands after the read and the check saw the old state
		if (sel && req.we && (m_lock[rgn] == "UNLK" || fld == FLD_LOCK))
			model_write(rgn, fld, req.dat);
		@(posedge clk);
		@(negedge clk);
		check_word("cfg_dato", exp_dato, cfg_dato);
		check_word("chk_resp.done", {31'h0, chk.valid}, {31'h0, chk_resp.done});
		if (chk.valid) begin
			check_word("chk_resp.fault", {31'h0, exp_fault}, {31'h0, chk_resp.fault});
			check_word("chk_resp.cacheable", {31'h0, exp_cache}, {31'h0, chk_resp.cacheable});
			check_word("chk_resp.pmt", exp_pmt, chk_resp.pmt);
		end
	endtask

	task automatic read_table();
		for (int r = 0; r < 8; r++)
			for (int f = 0; f < 4; f++)
				apply_cycle(1'b1, cfg_op(1'b0, r, f[1:0], 32'h0), '0);
	endtask

	// ====================
	// stimulus
	initial begin
		int          wait_cycles;
		cfg_req_t    req;
		chk_req_t    chk;
		logic        cs;
		logic [31:0] w;
		reset = 1'b1;
		cs_rgn = 1'b0;
		cfg_req = '0;
		chk_req = '0;
		load_model_defaults();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		wait_cycles = 0;
		while (cfg_dato !== 32'h0 || chk_resp.done !== 1'b0) begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > IDLE_TIMEOUT) begin
				$display("outputs did not go idle after reset");
				$display("RESULT: FAIL");
				$fatal(1, "idle timeout");
			end
		end

		read_table();	// default map
		for (int r = 0; r < 8; r++)	// locked, all ignored
			for (int f = 0; f < 3; f++)
				apply_cycle(1'b1, cfg_op(1'b1, r, f[1:0], rand_word()), '0);
		read_table();

		// open each region, fill it, lock it again
		for (int r = 0; r < 8; r++) begin
			apply_cycle(1'b1, cfg_op(1'b1, r, FLD_LOCK, UNLK_WORD), '0);
			for (int f = 0; f < 3; f++)
				apply_cycle(1'b1, cfg_op(1'b1, r, f[1:0], rand_word()), '0);
			for (int f = 0; f < 4; f++)
				apply_cycle(1'b1, cfg_op(1'b0, r, f[1:0], 32'h0), '0);
			apply_cycle(1'b1, cfg_op(1'b1, r, FLD_LOCK, LOCK_WORD), '0);
			apply_cycle(1'b1, cfg_op(1'b1, r, FLD_PMT, rand_word()), '0);
			apply_cycle(1'b1, cfg_op(1'b0, r, FLD_PMT, 32'h0), '0);
		end

		// checks mixed with writes, often to the checked region
		for (int i = 0; i < 400; i++) begin
			chk = rand_chk();
			chk.valid = (rand_word() & 3) != 0;
			req = cfg_op(rand_bit(), rand_word(), rand_word(), rand_word());
			if (rand_word() & 1)
				req.adr[8:6] = chk.rgn;	// collision
			if (req.adr[5:4] == FLD_LOCK)
				req.dat = (rand_word() & 1) ? UNLK_WORD : LOCK_WORD;
			apply_cycle(rand_bit(), req, chk);
		end
		read_table();

		// partial strobes, selected requests only read
		for (int i = 0; i < 300; i++) begin
			w = rand_word();
			req.adr = w[8:0];
			req.cyc = rand_bit();
			req.stb = rand_bit();
			req.we = rand_bit();
			req.dat = rand_word();
			cs = rand_bit();
			if (cs && req.cyc && req.stb)
				req.we = 1'b0;
			apply_cycle(cs, req, '0);
		end
		read_table();	// table untouched

		if (pma_unit_inst.properties_inst.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/pma_unit_properties.sv ====
// concurrent assertions on the pma unit ports
// bound to every pma_unit instance from the bottom of this file

module pma_unit_properties (
	input logic               clk,
	input logic               reset,
	input logic               cs_rgn,
	input pma_pkg::cfg_req_t  cfg_req,
	input logic [31:0]        cfg_dato,
	input pma_pkg::chk_req_t  chk_req,
	input pma_pkg::chk_resp_t chk_resp
);

	int   fail_count = 0;	// failed assertions so far
	logic cfg_sel;	// selected cfg request, read or write

	assign cfg_sel = cs_rgn && cfg_req.cyc && cfg_req.stb;

	// ====================
	// check port
	done_follows_valid: assert property (@(posedge clk) disable iff (reset)
		chk_req.valid |=> chk_resp.done)
		else begin $error("done missing after a valid check"); fail_count++; end

	done_only_after_valid: assert property (@(posedge clk) disable iff (reset)
		!chk_req.valid |=> !chk_resp.done)
		else begin $error("done without a valid check"); fail_count++; end

	fault_not_cacheable: assert property (@(posedge clk) disable iff (reset)
		chk_resp.fault |-> !chk_resp.cacheable)
		else begin $error("cacheable set on a faulting check"); fail_count++; end

	// ====================
	// cfg port and known outputs
	idle_reads_zero: assert property (@(posedge clk) disable iff (reset)
		!cfg_sel |=> cfg_dato == 32'h0)
		else begin $error("cfg_dato not zero after an idle cycle"); fail_count++; end

	outputs_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(cfg_dato) && !$isunknown(chk_resp))
		else begin $error("unknown value on an output"); fail_count++; end

endmodule

bind pma_unit pma_unit_properties properties_inst (.*);

// ==== rtl/pma_unit.sv ====
// top of the physical memory attribute unit
// cfg bus side reads and writes the region table
// check side looks up the tlb region and answers a cycle later

module pma_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               cs_rgn,
	input  pma_pkg::cfg_req_t  cfg_req,
	output logic [31:0]        cfg_dato,
	input  pma_pkg::chk_req_t  chk_req,
	output pma_pkg::chk_resp_t chk_resp
);

	import pma_pkg::*;

	region_t lookup;	// descriptor for chk_req.rgn

	// ====================
	// descriptor table
	pma_region_table region_table_inst (
		.clk        (clk),
		.reset      (reset),
		.cs_rgn     (cs_rgn),
		.cfg_req    (cfg_req),
		.cfg_dato   (cfg_dato),
		.lookup_rgn (chk_req.rgn),	// region from the tlb entry
		.lookup     (lookup)
	);

	// ====================
	// permission checker
	pma_access_check access_check_inst (
		.clk      (clk),
		.reset    (reset),
		.chk_req  (chk_req),
		.lookup   (lookup),
		.chk_resp (chk_resp)
	);

endmodule

// ==== rtl/pma_access_check.sv ====
// permission check for one access against a looked-up descriptor
// one pipeline stage, a response every cycle a request was valid
// picks the attribute entry for the privilege level and tests the
// rwx bit that the access kind needs

module pma_access_check (
	input  logic               clk,
	input  logic               reset,
	input  pma_pkg::chk_req_t  chk_req,
	input  pma_pkg::region_t   lookup,
	output pma_pkg::chk_resp_t chk_resp
);

	import pma_pkg::*;

	// ====================
	// decode
	attr_entry_t      ent;	// entry for this privilege level
	logic             need_bit;	// rwx bit the access needs
	logic             no_dev;
	logic             fault_c;
	logic             cache_c;

	logic             done_q;
	logic             fault_q;
	logic             cacheable_q;
	logic [ABITS-1:0] pmt_q;

	always_comb begin
		ent = lookup.at.entries[chk_req.priv];

		case (chk_req.kind)
			ACC_READ: need_bit = ent.rwx[2];
			ACC_WRITE: need_bit = ent.rwx[1];
			ACC_EXEC: need_bit = ent.rwx[0];
			default: need_bit = 1'b0;	// unused code always faults
		endcase

		no_dev  = (ent.dev_type == DEV_NONE);
		fault_c = no_dev || !need_bit;
		cache_c = ent.rwx[3] && !fault_c;	// never cacheable on fault
	end

	// ====================
	// response register
	always_ff @(posedge clk) begin
		if (reset) begin
			done_q      <= 1'b0;
			fault_q     <= 1'b0;
			cacheable_q <= 1'b0;
			pmt_q       <= '0;
		end else begin
			done_q <= chk_req.valid;	// one cycle behind the strobe
			if (chk_req.valid) begin
				fault_q     <= fault_c;
				cacheable_q <= cache_c;
				pmt_q       <= lookup.pmt;
			end
		end
	end

	// back to back requests come out in order, one per cycle
	assign chk_resp.done      = done_q;
	assign chk_resp.fault     = fault_q;
	assign chk_resp.cacheable = cacheable_q;
	assign chk_resp.pmt       = pmt_q;

endmodule

// ==== rtl/pma_region_table.sv ====
// descriptor storage for the eight pma regions
// cfg bus writes are guarded by each region's lock word
// cfg reads come back one cycle later, zero when no read was selected
// the lookup port indexes the table combinationally for the checker

module pma_region_table (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        cs_rgn,
	input  pma_pkg::cfg_req_t           cfg_req,
	output logic [31:0]                 cfg_dato,
	input  logic [pma_pkg::RGN_BITS-1:0] lookup_rgn,
	output pma_pkg::region_t            lookup
);

	import pma_pkg::*;

	// ====================
	// storage and decode
	region_t regions [0:NUM_REGIONS-1];

	logic [RGN_BITS-1:0] cfg_rgn;	// adr[8:6]
	logic [1:0]          cfg_fld;	// adr[5:4]
	logic                rd_sel;	// selected request, read or write
	logic                wr_sel;
	logic                unlocked;	// addressed region reads UNLK
	logic                wr_ok;
	logic [31:0]         rd_word;

	assign cfg_rgn = cfg_req.adr[8:6];
	assign cfg_fld = cfg_req.adr[5:4];

	// no ack, a request is just cs plus the two strobes
	assign rd_sel = cs_rgn && cfg_req.cyc && cfg_req.stb;
	assign wr_sel = rd_sel && cfg_req.we;

	assign unlocked = (regions[cfg_rgn].lock == UNLK_WORD);

	// lock word itself stays writable so a region can be opened
	assign wr_ok = wr_sel && (unlocked || cfg_fld == FLD_LOCK);

	// ====================
	// write port
	always_ff @(posedge clk) begin
		if (reset) begin
			regions <= RESET_TABLE;	// default map
		end else if (wr_ok) begin
			case (cfg_fld)
				FLD_PMT: regions[cfg_rgn].pmt <= cfg_req.dat;
				FLD_CTA: regions[cfg_rgn].cta <= cfg_req.dat;
				FLD_AT: regions[cfg_rgn].at.raw <= cfg_req.dat;	// bus view
				FLD_LOCK: regions[cfg_rgn].lock <= cfg_req.dat;
				default: ;
			endcase
		end
	end

	// ====================
	// read port
	always_comb begin
		case (cfg_fld)
			FLD_PMT: rd_word = regions[cfg_rgn].pmt;
			FLD_CTA: rd_word = regions[cfg_rgn].cta;
			FLD_AT: rd_word = regions[cfg_rgn].at.raw;
			FLD_LOCK: rd_word = regions[cfg_rgn].lock;
			default: rd_word = '0;
		endcase
	end

	// old value on a same-edge write, since the table updates at this edge too
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_dato <= '0;
		end else if (rd_sel) begin
			cfg_dato <= rd_word;
		end else begin
			cfg_dato <= '0;	// idle cycles read back zero
		end
	end

	// lookup for the checker, sees pre-write state on a collision
	assign lookup = regions[lookup_rgn];

endmodule

// ==== rtl/pma_pkg.sv ====
// shared definitions for the physical memory attribute unit
// widths, cfg field codes, descriptor types and the reset table
// imported by every rtl block of the unit

package pma_pkg;

	// ====================
	// sizes
	localparam int ABITS       = 32;	// address width
	localparam int NUM_REGIONS = 8;
	localparam int RGN_BITS    = 3;
	localparam int PRIV_LEVELS = 4;	// one attribute entry per level

	// field select on cfg adr[5:4]
	localparam logic [1:0] FLD_PMT  = 2'd0;
	localparam logic [1:0] FLD_CTA  = 2'd1;
	localparam logic [1:0] FLD_AT   = 2'd2;
	localparam logic [1:0] FLD_LOCK = 2'd3;

	localparam logic [31:0] LOCK_WORD = 32'h4C4F434B;	// "LOCK"
	localparam logic [31:0] UNLK_WORD = 32'h554E4C4B;	// "UNLK"
	localparam logic [3:0]  DEV_NONE  = 4'hF;	// no access

	// ====================
	// types
	typedef enum logic [1:0] {
		ACC_READ  = 2'd0,
		ACC_WRITE = 2'd1,
		ACC_EXEC  = 2'd2
	} access_kind_e;

	typedef struct packed {
		logic [3:0] rwx;	// cache, read, write, exec
		logic [3:0] dev_type;
	} attr_entry_t;

	// bus writes the raw word, checker decodes per privilege level
	typedef union packed {
		logic [31:0] raw;
		attr_entry_t [PRIV_LEVELS-1:0] entries;
	} attr_word_u;

	typedef struct packed {
		logic [ABITS-1:0] pmt;	// page management table base
		logic [ABITS-1:0] cta;	// card table base
		attr_word_u at;
		logic [31:0] lock;
	} region_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [8:0] adr;	// word address, 8:6 region, 5:4 field
		logic [31:0] dat;
	} cfg_req_t;

	typedef struct packed {
		logic valid;
		logic [RGN_BITS-1:0] rgn;	// region number from the tlb entry
		logic [1:0] priv;
		access_kind_e kind;
	} chk_req_t;

	typedef struct packed {
		logic done;
		logic fault;
		logic cacheable;
		logic [ABITS-1:0] pmt;
	} chk_resp_t;

	// ====================
	// reset table
	localparam attr_entry_t ENT_ROM    = '{rwx: 4'hD, dev_type: 4'h0};
	localparam attr_entry_t ENT_RW     = '{rwx: 4'h6, dev_type: 4'h0};
	localparam attr_entry_t ENT_RAM    = '{rwx: 4'hF, dev_type: 4'h0};
	localparam attr_entry_t ENT_DRAM   = '{rwx: 4'hF, dev_type: 4'h1};
	localparam attr_entry_t ENT_VACANT = '{rwx: 4'h0, dev_type: DEV_NONE};

	// same entry at every privilege level, cta clear, locked
	function automatic region_t make_region(logic [ABITS-1:0] pmt, attr_entry_t ent);
		region_t r;
		r.pmt    = pmt;
		r.cta    = '0;
		r.at.raw = {PRIV_LEVELS{ent}};
		r.lock   = LOCK_WORD;
		return r;
	endfunction

	localparam region_t RESET_TABLE [0:NUM_REGIONS-1] = '{
		make_region(32'h0000_0000, ENT_VACANT),	// 0 vacant
		make_region(32'h0000_2400, ENT_DRAM),	// 1 dram
		make_region(32'h0000_0000, ENT_VACANT),	// 2 vacant
		make_region(32'h0000_0000, ENT_VACANT),	// 3 vacant
		make_region(32'h0000_2300, ENT_RAM),	// 4 scratchpad
		make_region(32'h0000_0000, ENT_RW),	// 5 config space
		make_region(32'h0000_0300, ENT_RW),	// 6 io
		make_region(32'h0000_0000, ENT_ROM)	// 7 rom
	};

endpackage
